// File: pmp_chk.sv
// ------------------------------
// Concurrent checks bound into pmp_top
// Only active outside reset
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module pmp_chk (
    input logic              g_clk,
    input logic              g_resetn,
    input pmp_pkg::csr_rsp_t csr_rsp,
    input pmp_pkg::pmp_req_t imem_req,
    input logic              imem_trap,
    input logic              imem_error,
    input pmp_pkg::pmp_req_t dmem_req,
    input logic              dmem_trap,
    input logic              dmem_error
);

    // Error is trap one cycle late
    a_ierr: assert property (@(posedge g_clk) disable iff (!g_resetn)
        $past(g_resetn) |-> imem_error == $past(imem_trap))
        else $error("imem_error does not follow imem_trap");
    a_derr: assert property (@(posedge g_clk) disable iff (!g_resetn)
        $past(g_resetn) |-> dmem_error == $past(dmem_trap))
        else $error("dmem_error does not follow dmem_trap");

    // No trap without a request
    a_ivld: assert property (@(posedge g_clk) imem_trap |-> imem_req.valid)
        else $error("imem_trap without valid");
    a_dvld: assert property (@(posedge g_clk) dmem_trap |-> dmem_req.valid)
        else $error("dmem_trap without valid");

    a_csr: assert property (@(posedge g_clk) csr_rsp.error |-> csr_rsp.rdata == '0)
        else $error("csr error with nonzero rdata");

endmodule

bind pmp_top pmp_chk u_chk (
    .g_clk      (g_clk),
    .g_resetn   (g_resetn),
    .csr_rsp    (csr_rsp),
    .imem_req   (imem_req),
    .imem_trap  (imem_trap),
    .imem_error (imem_error),
    .dmem_req   (dmem_req),
    .dmem_trap  (dmem_trap),
    .dmem_error (dmem_error)
);

`default_nettype wire

// File: pmp_csr_file.sv
// ------------------------------
// PMP config and address registers
// Writes need en and wr, set and clr modify wdata
// Locked bytes stay fixed until reset
// Response is combinational on the request
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module pmp_csr_file (
    input  logic                 g_clk,
    input  logic                 g_resetn,
    input  pmp_pkg::csr_req_t    csr,
    output pmp_pkg::csr_rsp_t    csr_rsp,
    output pmp_pkg::pmp_region_t regions [pmp_pkg::pmp_num_regions]
);

    localparam int nr = pmp_pkg::pmp_num_regions;
    localparam int aw = pmp_pkg::pmp_aw;
    localparam int dw = pmp_pkg::csr_dw;

    pmp_pkg::pmp_cfg_t cfg_q  [nr];   // Config bytes
    logic [aw-1:0]     addr_q [nr];   // Address registers

    logic [dw-1:0] cfg_word;          // Packed view of pmpcfg0
    logic [dw-1:0] cfg_wval;          // New pmpcfg0 value before lock masking
    logic [dw-1:0] addr_rd;           // Selected address register, zero padded
    logic [nr-1:0] addr_hit;          // One-hot address CSR select
    logic          is_cfg;            // Any even config CSR
    logic          is_cfg0;           // The only populated one
    logic          is_addr;           // Any of the 16 address CSRs
    logic          wr_en;

    // Plain write, set or clear
    function automatic logic [dw-1:0] write_val(
        input logic [dw-1:0] old,
        input logic [dw-1:0] wd,
        input logic          set,
        input logic          clr
    );
        if (set) begin
            write_val = old | wd;
        end else if (clr) begin
            write_val = old & ~wd;
        end else begin
            write_val = wd;
        end
    endfunction

    // Decode ------------------------
    assign is_cfg  = (csr.num[11:4] == pmp_pkg::csr_cfg_base[11:4]) && !csr.num[0];
    assign is_cfg0 = csr.num == pmp_pkg::csr_cfg_base;
    assign is_addr = csr.num[11:4] == pmp_pkg::csr_addr_base[11:4];
    assign wr_en   = csr.en && csr.wr;

    always_comb begin
        cfg_word = '0;                       // Bytes above the last region read zero
        for (int i = 0; i < nr; i++) begin
            cfg_word[8*i +: 8] = cfg_q[i];   // Byte i is region i
        end
    end

    assign cfg_wval = write_val(cfg_word, csr.wdata, csr.set, csr.clr);

    // Per region registers ----------
    for (genvar i = 0; i < nr; i++) begin : g_region
        logic          tor_lock;   // Region above is a locked TOR
        logic [dw-1:0] addr_new;

        if (i < nr - 1) begin : g_above
            assign tor_lock = cfg_q[i+1].lock && (cfg_q[i+1].mode == pmp_pkg::a_tor);
        end else begin : g_top
            assign tor_lock = 1'b0;          // Nothing above the last region
        end

        assign addr_hit[i] = csr.num == (pmp_pkg::csr_addr_base + 12'(i));
        assign addr_new    = write_val({{(dw-aw){1'b0}}, addr_q[i]}, csr.wdata,
                                       csr.set, csr.clr);

        always_ff @(posedge g_clk) begin
            if (!g_resetn) begin
                cfg_q[i] <= '0;              // All regions off
            end else if (wr_en && is_cfg0 && !cfg_q[i].lock) begin
                cfg_q[i] <= cfg_wval[8*i +: 8];   // Reserved bits kept as written
            end
        end

        always_ff @(posedge g_clk) begin
            if (!g_resetn) begin
                addr_q[i] <= '0;
            end else if (wr_en && addr_hit[i] && !cfg_q[i].lock && !tor_lock) begin
                addr_q[i] <= addr_new[aw-1:0];    // Upper CSR bits dropped
            end
        end

        // Checker view
        assign regions[i].cfg  = cfg_q[i];
        assign regions[i].addr = addr_q[i];
    end

    // Read mux ----------------------
    always_comb begin
        addr_rd = '0;                        // Unpopulated address CSRs read zero
        for (int i = 0; i < nr; i++) begin
            if (addr_hit[i]) begin
                addr_rd = {{(dw-aw){1'b0}}, addr_q[i]};
            end
        end
    end

    always_comb begin
        csr_rsp.error = !(is_cfg || is_addr);
        if (is_cfg0) begin
            csr_rsp.rdata = cfg_word;
        end else if (is_addr) begin
            csr_rsp.rdata = addr_rd;
        end else begin
            csr_rsp.rdata = '0;              // Also covers odd and empty config CSRs
        end
    end

endmodule

`default_nettype wire

// File: pmp_pkg.sv
// ------------------------------
// Shared PMP definitions for the RV64 CSR layout
// Eight regions with word addresses only
// Only config CSR 0x3A0 carries bytes
// ------------------------------
`default_nettype none

package pmp_pkg;

    // Sizes ------------------------
    localparam int pmp_num_regions = 8;     // Protection regions
    localparam int pmp_aw          = 32;    // Word address width
    localparam int csr_dw          = 64;    // CSR data width

    // CSR numbers ------------------
    localparam logic [11:0] csr_cfg_base  = 12'h3A0;  // pmpcfg0
    localparam logic [11:0] csr_addr_base = 12'h3B0;  // pmpaddr0

    // Address matching modes in cfg bits 4:3
    localparam logic [1:0] a_off   = 2'b00;  // Region disabled
    localparam logic [1:0] a_tor   = 2'b01;  // Top of range
    localparam logic [1:0] a_na4   = 2'b10;  // Single word
    localparam logic [1:0] a_napot = 2'b11;  // Aligned power of two

    // One config byte in CSR bit order
    typedef struct packed {
        logic       lock;   // Bit 7 also binds machine mode
        logic [1:0] rsvd;   // Bits 6:5
        logic [1:0] mode;   // Bits 4:3
        logic       x;      // Execute allowed
        logic       w;      // Write allowed
        logic       r;      // Read allowed
    } pmp_cfg_t;

    // 40-bit region as the checkers see it
    typedef struct packed {
        pmp_cfg_t            cfg;
        logic [pmp_aw-1:0]   addr;
    } pmp_region_t;

    // Access kind picks the permission bit
    typedef enum logic [1:0] {
        acc_read  = 2'd0,
        acc_write = 2'd1,
        acc_exec  = 2'd2
    } pmp_acc_e;

    // 36-bit access check request
    typedef struct packed {
        logic              valid;   // Check this cycle
        logic              mmode;   // Machine mode when set
        pmp_acc_e          kind;
        logic [pmp_aw-1:0] addr;    // Word address
    } pmp_req_t;

    // 80-bit CSR access
    typedef struct packed {
        logic              en;      // Access enable
        logic              wr;      // Set and clear need it too
        logic              set;     // OR wdata into old value
        logic              clr;     // Clear the bits of wdata
        logic [11:0]       num;     // CSR number
        logic [csr_dw-1:0] wdata;
    } csr_req_t;

    // 65-bit CSR response
    typedef struct packed {
        logic [csr_dw-1:0] rdata;
        logic              error;   // Number outside both ranges
    } csr_rsp_t;

endpackage

`default_nettype wire

// File: pmp_port_check.sv
// ------------------------------
// PMP check for one access port
// trap is combinational, error is trap one cycle later
// Lowest numbered matching region decides
// Machine mode is bound by locked regions only
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module pmp_port_check (
    input  logic                 g_clk,
    input  logic                 g_resetn,
    input  pmp_pkg::pmp_region_t regions [pmp_pkg::pmp_num_regions],
    input  pmp_pkg::pmp_req_t    req,
    output logic                 trap,
    output logic                 error
);

    localparam int nr = pmp_pkg::pmp_num_regions;
    localparam int aw = pmp_pkg::pmp_aw;

    logic [aw-1:0] tor_base [nr];   // Lower TOR bound per region
    logic [nr-1:0] hit;             // Region matches req.addr
    logic [nr-1:0] perm;            // Region grants req.kind
    logic [nr-1:0] lock;            // Region is locked
    logic          any_hit;
    logic          sel_perm;        // Permission of the winning region
    logic          sel_lock;        // Lock of the winning region
    logic          deny;

    // Matching functions -----------

    // Low bound inclusive, top exclusive
    function automatic logic tor_hit(
        input logic [aw-1:0] a,
        input logic [aw-1:0] base,
        input logic [aw-1:0] top
    );
        tor_hit = (a >= base) && (a < top);
    endfunction

    // t trailing ones give a block of 2^(t+1) words
    function automatic logic napot_hit(
        input logic [aw-1:0] a,
        input logic [aw-1:0] r
    );
        logic [aw-1:0] dont_care;
        dont_care = r ^ (r + 1'b1);          // Ones in bits t down to 0
        napot_hit = ((a ^ r) & ~dont_care) == '0;
    endfunction

    // Permission bit for the access kind
    function automatic logic perm_bit(
        input pmp_pkg::pmp_cfg_t cfg,
        input pmp_pkg::pmp_acc_e kind
    );
        case (kind)
            pmp_pkg::acc_read:  perm_bit = cfg.r;
            pmp_pkg::acc_write: perm_bit = cfg.w;
            pmp_pkg::acc_exec:  perm_bit = cfg.x;
            default:            perm_bit = 1'b0;   // Unused code, never granted
        endcase
    endfunction

    // Per region match -------------
    for (genvar i = 0; i < nr; i++) begin : g_match
        logic hit_i;

        if (i == 0) begin : g_first
            assign tor_base[i] = '0;         // Region 0 TOR starts at zero
        end else begin : g_next
            assign tor_base[i] = regions[i-1].addr;
        end

        always_comb begin
            case (regions[i].cfg.mode)
                pmp_pkg::a_off:   hit_i = 1'b0;
                pmp_pkg::a_tor:   hit_i = tor_hit(req.addr, tor_base[i], regions[i].addr);
                pmp_pkg::a_na4:   hit_i = req.addr == regions[i].addr;
                pmp_pkg::a_napot: hit_i = napot_hit(req.addr, regions[i].addr);
            endcase
        end

        assign hit[i]  = hit_i;
        assign perm[i] = perm_bit(regions[i].cfg, req.kind);
        assign lock[i] = regions[i].cfg.lock;
    end

    // Priority, scanned top down so the lowest hit wins
    always_comb begin
        any_hit  = 1'b0;
        sel_perm = 1'b0;
        sel_lock = 1'b0;
        for (int k = nr - 1; k >= 0; k--) begin
            if (hit[k]) begin
                any_hit  = 1'b1;
                sel_perm = perm[k];
                sel_lock = lock[k];
            end
        end
    end

    // Decision ----------------------
    always_comb begin
        if (req.mmode) begin
            deny = any_hit && sel_lock && !sel_perm;   // No match means allowed
        end else begin
            deny = !any_hit || !sel_perm;              // User mode needs a grant
        end
    end

    assign trap = req.valid && deny;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            error <= 1'b0;
        end else begin
            error <= trap;                   // Error response a cycle behind
        end
    end

endmodule

`default_nettype wire

// File: pmp_top.sv
// ------------------------------
// PMP unit, one CSR file and two checkers
// Fetch port carries exec requests only
// Data port carries read or write requests
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module pmp_top (
    input  logic              g_clk,
    input  logic              g_resetn,
    input  pmp_pkg::csr_req_t csr,
    output pmp_pkg::csr_rsp_t csr_rsp,
    input  pmp_pkg::pmp_req_t imem_req,
    output logic              imem_trap,
    output logic              imem_error,
    input  pmp_pkg::pmp_req_t dmem_req,
    output logic              dmem_trap,
    output logic              dmem_error
);

    // Shared region state
    pmp_pkg::pmp_region_t regions [pmp_pkg::pmp_num_regions];

    pmp_csr_file u_csr (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .csr      (csr),
        .csr_rsp  (csr_rsp),
        .regions  (regions)
    );

    // Instruction side --------------
    pmp_port_check u_ichk (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .regions  (regions),
        .req      (imem_req),    // Kind selects the x bit
        .trap     (imem_trap),
        .error    (imem_error)
    );

    // Data side ---------------------
    pmp_port_check u_dchk (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .regions  (regions),
        .req      (dmem_req),    // Kind selects r or w
        .trap     (dmem_trap),
        .error    (dmem_error)
    );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the PMP testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_pmp \
    -f sources.f \
    -o sim_pmp

./obj_dir/sim_pmp > sim.log 2>&1 || true
cat sim.log

if grep -q "Checks failed" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
echo "Simulation passed"
exit 0

// File: sources.f
pmp_pkg.sv
pmp_csr_file.sv
pmp_port_check.sv
pmp_top.sv
pmp_chk.sv
tb_clkgen.sv
tb_pmp.sv

// File: tb_clkgen.sv
// ------------------------------
// Testbench clock and reset, 4 ns period
// Reset low for 3 rising edges at start and after restart
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_clkgen (
    input  logic restart,     // Sampled on the rising edge
    output logic g_clk,
    output logic g_resetn
);

    int rst_cnt = 3;          // Edges of reset still to go

    initial g_clk = 1'b0;
    always #2 g_clk = ~g_clk;

    always @(posedge g_clk) begin
        if (restart) begin
            rst_cnt <= 3;
        end else if (rst_cnt > 0) begin
            rst_cnt <= rst_cnt - 1;
        end
    end

    assign g_resetn = (rst_cnt == 0);

endmodule

`default_nettype wire

// File: tb_pmp.sv
// ------------------------------
// PMP testbench with LCG stimulus against a reference model
// Inputs change 1 ns after the edge and outputs are sampled at 2 ns
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_pmp;

    // Test lengths in cycles with some headroom
    localparam int t1_len  = 220;
    localparam int t2_len  = 100;
    localparam int t3_len  = 340;
    localparam int t4_len  = 460;
    localparam int timeout = t1_len + t2_len + t3_len + t4_len + 100;

    logic               g_clk;
    logic               g_resetn;
    logic               restart;
    pmp_pkg::csr_req_t  csr;
    pmp_pkg::csr_rsp_t  csr_rsp;
    pmp_pkg::pmp_req_t  imem_req;
    pmp_pkg::pmp_req_t  dmem_req;
    logic               imem_trap;
    logic               imem_error;
    logic               dmem_trap;
    logic               dmem_error;

    logic [31:0] seed = 32'h6235aff7;
    logic [7:0]  m_cfg  [8];          // Model config bytes
    logic [31:0] m_addr [8];          // Model address registers
    logic        prev_i;              // Expected trap of last cycle
    logic        prev_d;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          test_err0;

    tb_clkgen u_clk (.restart(restart), .g_clk(g_clk), .g_resetn(g_resetn));

    pmp_top DUT (
        .g_clk(g_clk), .g_resetn(g_resetn), .csr(csr), .csr_rsp(csr_rsp),
        .imem_req(imem_req), .imem_trap(imem_trap), .imem_error(imem_error),
        .dmem_req(dmem_req), .dmem_trap(dmem_trap), .dmem_error(dmem_error)
    );

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Model ------------------------
    function automatic logic [63:0] read_model(input logic [11:0] num, output logic err);
        logic [63:0] v;
        v   = '0;
        err = 1'b0;
        if (num[11:4] == 8'h3A && !num[0]) begin
            if (num == 12'h3A0) begin
                for (int i = 0; i < 8; i++) begin
                    v[8*i +: 8] = m_cfg[i];
                end
            end
        end else if (num[11:4] == 8'h3B) begin
            if (!num[3]) begin
                v = {32'h0, m_addr[num[2:0]]};   // Regions 8..15 empty
            end
        end else begin
            err = 1'b1;
        end
        return v;
    endfunction

    task automatic update_model(input logic [11:0] num, input logic set, input logic clr,
                                input logic [63:0] wd);
        logic [63:0] old;
        logic [63:0] nv;
        logic        e;
        int          k;
        old = read_model(num, e);
        nv  = set ? (old | wd) : (clr ? (old & ~wd) : wd);
        if (num == 12'h3A0) begin
            for (int i = 0; i < 8; i++) begin
                if (!m_cfg[i][7]) begin
                    m_cfg[i] = nv[8*i +: 8];     // Locked bytes stay
                end
            end
        end else if (num[11:4] == 8'h3B && !num[3]) begin   // 0x3B0..0x3B7
            k = int'(num[2:0]);
            if (!m_cfg[k][7] && !(k < 7 && m_cfg[k+1][7] && m_cfg[k+1][4:3] == 2'b01)) begin
                m_addr[k] = nv[31:0];
            end
        end
    endtask

    // Lowest matching region decides
    function automatic logic predict_trap(input logic mm, input logic [1:0] kind,
                                          input logic [31:0] a);
        logic        found;
        logic        hit;
        logic        perm;
        logic        lck;
        logic [31:0] base;
        logic [31:0] mask;
        int          t;
        found = 1'b0;
        perm  = 1'b0;
        lck   = 1'b0;
        for (int i = 0; i < 8; i++) begin
            hit = 1'b0;
            case (m_cfg[i][4:3])
                2'b01: begin
                    base = (i == 0) ? 32'h0 : m_addr[i-1];
                    hit  = (a >= base) && (a < m_addr[i]);
                end
                2'b10: hit = (a == m_addr[i]);
                2'b11: begin
                    t = 0;
                    while (t < 32 && m_addr[i][t]) begin
                        t++;
                    end
                    if (t >= 31) begin
                        hit = 1'b1;                  // Block covers all addresses
                    end else begin
                        mask = (32'h1 << (t + 1)) - 32'h1;
                        hit  = (a & ~mask) == (m_addr[i] & ~mask);
                    end
                end
                default: hit = 1'b0;
            endcase
            if (hit && !found) begin
                found = 1'b1;
                perm  = (kind == 2'd3) ? 1'b0 : m_cfg[i][kind];   // r, w, x in bits 0..2
                lck   = m_cfg[i][7];
            end
        end
        return mm ? (found && lck && !perm) : (!found || !perm);
    endfunction

    // Helpers -----------------------
    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Fail %s at %0t: got 0x%0h, expected 0x%0h", name, $time, got, exp);
            errors++;
        end
    endtask

    // User-mode requests that trap while all regions are off
    task automatic hold_trap_reqs();
        imem_req       = '0;
        dmem_req       = '0;
        imem_req.valid = 1'b1;
        imem_req.kind  = pmp_pkg::acc_exec;
        dmem_req.valid = 1'b1;
    endtask

    // Error reads zero after reset while trapping requests are held
    task automatic verify_reset_error();
        #1;
        check_val("imem_error", {63'h0, imem_error}, 64'h0);
        check_val("dmem_error", {63'h0, dmem_error}, 64'h0);
        imem_req.valid = 1'b0;
        dmem_req.valid = 1'b0;
        prev_i = 1'b0;
        prev_d = 1'b0;
    endtask

    task automatic csr_op(input logic [11:0] num, input logic wr, input logic set,
                          input logic clr, input logic [63:0] wd);
        logic [63:0] exp_rd;
        logic        exp_err;
        @(posedge g_clk);
        #1;
        csr            = '{en: 1'b1, wr: wr, set: set, clr: clr, num: num, wdata: wd};
        imem_req.valid = 1'b0;
        dmem_req.valid = 1'b0;
        prev_i = 1'b0;
        prev_d = 1'b0;
        #1;
        exp_rd = read_model(num, exp_err);
        check_val("csr_rsp.rdata", csr_rsp.rdata, exp_rd);
        check_val("csr_rsp.error", {63'h0, csr_rsp.error}, {63'h0, exp_err});
        if (wr) begin
            update_model(num, set, clr, wd);             // Lands on the next edge
        end
    endtask

    task automatic req_cycle(input pmp_pkg::pmp_req_t ir, input pmp_pkg::pmp_req_t dr);
        logic exp_i;
        logic exp_d;
        @(posedge g_clk);
        #1;
        csr.en   = 1'b0;
        imem_req = ir;
        dmem_req = dr;
        #1;
        check_val("imem_error", {63'h0, imem_error}, {63'h0, prev_i});
        check_val("dmem_error", {63'h0, dmem_error}, {63'h0, prev_d});
        exp_i = ir.valid && predict_trap(ir.mmode, ir.kind, ir.addr);
        exp_d = dr.valid && predict_trap(dr.mmode, dr.kind, dr.addr);
        check_val("imem_trap", {63'h0, imem_trap}, {63'h0, exp_i});
        check_val("dmem_trap", {63'h0, dmem_trap}, {63'h0, exp_d});
        prev_i = exp_i;
        prev_d = exp_d;
    endtask

    task automatic do_restart();
        @(posedge g_clk);
        #1;
        csr.en  = 1'b0;
        hold_trap_reqs();
        restart = 1'b1;
        @(posedge g_clk);
        #1;
        restart = 1'b0;
        wait (g_resetn === 1'b1);
        verify_reset_error();
        for (int i = 0; i < 8; i++) begin
            m_cfg[i]  = '0;
            m_addr[i] = '0;
        end
    endtask

    // Addresses go before pmpcfg0 so TOR locks do not block them
    task automatic program_regions(input logic allow_lock, input logic [31:0] base);
        logic [63:0] cw;
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] cur;
        logic [1:0]  mode;
        int          t;
        cw  = '0;
        cur = base;
        for (int i = 0; i < 8; i++) begin
            r    = next_rand();
            mode = r[1:0];
            t    = int'(r[16:14]);
            if (mode == 2'b01) begin
                cur = cur + 32'(r[7:2]) + 32'd1;         // Ascending TOR tops
                a   = cur;
            end else if (mode == 2'b11) begin
                a = ((base + 32'(r[13:8])) & ~((32'h1 << (t + 1)) - 32'h1))
                    | ((32'h1 << t) - 32'h1);
            end else begin
                a = base + 32'(r[13:8]);
            end
            csr_op(12'h3B0 + 12'(i), 1'b1, 1'b0, 1'b0, {32'h0, a});
            cw[8*i +: 8] = {allow_lock & r[20], 2'b00, mode, r[23:21]};
        end
        csr_op(12'h3A0, 1'b1, 1'b0, 1'b0, cw);
    endtask

    // Mix of edge hits and window addresses
    function automatic pmp_pkg::pmp_req_t make_req(input logic fetch, input logic mm_en,
                                                   input logic [31:0] base);
        pmp_pkg::pmp_req_t q;
        logic [31:0]       r;
        r       = next_rand();
        q.valid = r[15] | r[16] | r[17];
        q.mmode = mm_en & r[18];
        q.kind  = fetch ? pmp_pkg::acc_exec : (r[19] ? pmp_pkg::acc_write : pmp_pkg::acc_read);
        if (r[0]) begin
            q.addr = m_addr[r[3:1]] + 32'(r[6:4]) - 32'd3;
        end else begin
            q.addr = base - 32'd16 + 32'(r[14:7]);
        end
        return q;
    endfunction

    task automatic end_test(input string name);
        $display("Test %s finished, %0d errors", name, errors - test_err0);
        test_err0 = errors;
    endtask

    // Timeout ---------------------
    always @(posedge g_clk) begin
        cycles++;
        if (cycles > timeout) begin
            $display("Timeout, run stopped after %0d cycles", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        logic [31:0] r;
        logic [11:0] num;
        logic [63:0] wd;
        restart   = 1'b0;
        csr       = '0;
        csr.num   = 12'h3A0;
        hold_trap_reqs();
        test_err0 = 0;
        for (int i = 0; i < 8; i++) begin
            m_cfg[i]  = '0;
            m_addr[i] = '0;
        end
        prev_i = 1'b0;
        prev_d = 1'b0;
        wait (g_resetn === 1'b1);
        verify_reset_error();

        // Reset values and CSR access
        for (int n = 0; n < 32; n++) begin
            csr_op(12'h3A0 + 12'(n), 1'b0, 1'b0, 1'b0, '0);
        end
        for (int n = 0; n < 150; n++) begin
            r   = next_rand();
            num = (r[4:2] == 3'd0) ? r[27:16] : (12'h3A0 + 12'(r[9:5]));
            wd  = {next_rand(), next_rand()};
            if (num[11:4] == 8'h3A) begin
                wd = wd & 64'h7f7f7f7f7f7f7f7f;    // No locks yet
            end
            csr_op(num, r[11:10] != 2'd0, r[11:10] == 2'd2, r[11:10] == 2'd3, wd);
        end
        end_test("csr_access");

        // Locks against later writes
        do_restart();
        program_regions(1'b1, 32'h4000);
        for (int n = 0; n < 40; n++) begin
            r   = next_rand();
            num = r[3] ? 12'h3A0 : (12'h3B0 + 12'(r[2:0]));
            csr_op(num, 1'b1, r[5:4] == 2'd1, r[5:4] == 2'd2, {next_rand(), next_rand()});
        end
        csr_op(12'h3A0, 1'b0, 1'b0, 1'b0, '0);
        for (int n = 0; n < 8; n++) begin
            csr_op(12'h3B0 + 12'(n), 1'b0, 1'b0, 1'b0, '0);
        end
        end_test("locking");

        // Matching modes in user mode
        do_restart();
        program_regions(1'b0, 32'h1000);
        for (int n = 0; n < 300; n++) begin
            req_cycle(make_req(1'b1, 1'b0, 32'h1000), make_req(1'b0, 1'b0, 32'h1000));
        end
        end_test("matching");

        // Overlap, priority and machine mode
        for (int k = 0; k < 2; k++) begin
            do_restart();
            program_regions(1'b1, 32'h2000);
            for (int n = 0; n < 200; n++) begin
                req_cycle(make_req(1'b1, 1'b1, 32'h2000), make_req(1'b0, 1'b1, 32'h2000));
            end
        end
        end_test("priority");

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
